//--- hdl/flush_pkg.sv
// Flush control shared definitions

package flush_pkg;

    // ------------------------------
    // Cache geometry and timing
    // ------------------------------
    localparam int unsigned DCACHE_SETS = 8;                   // Sets walked per flush
    localparam int unsigned WB_CYCLES   = 2;                   // Extra cycles per dirty set
    localparam int unsigned SET_W       = $clog2(DCACHE_SETS); // Set index width
    localparam int unsigned WB_CNT_W    = (WB_CYCLES > 1) ? $clog2(WB_CYCLES) : 1;

    // Widths that carry a meaning
    typedef logic [SET_W-1:0] set_idx_t;  // Data cache set index
    typedef logic [SET_W:0]   wb_count_t; // Sets written back, 0 to DCACHE_SETS

    // ------------------------------
    // Commit side
    // ------------------------------
    // Class of the committed instruction
    typedef enum logic [2:0] {
        OP_PLAIN,      // No side effect
        OP_FENCE,      // Memory fence
        OP_FENCE_I,    // Instruction fence
        OP_SFENCE_VMA, // Address translation fence
        OP_CSR_SIDE,   // CSR write with side effect
        OP_ERET        // Return from trap
    } commit_op_t;

    // One-cycle strobes out of the commit decoder
    typedef struct packed {
        logic fence;        // fence committed
        logic fence_i;      // fence.i committed
        logic sfence_vma;   // sfence.vma committed
        logic flush_csr;    // CSR side effect
        logic ex_valid;     // Exception taken
        logic eret;         // Trap return
        logic set_debug_pc; // Enter debug mode
    } commit_event_t;

    // Branch outcome from the execute stage
    typedef struct packed {
        logic valid;         // Branch resolved this cycle
        logic is_mispredict; // Prediction was wrong
    } branch_res_t;

    // Flush strobes to the core
    typedef struct packed {
        logic set_pc_commit;  // Restart fetch at the commit PC
        logic flush_if;       // Fetch stage
        logic flush_unissued; // Scoreboard entries not yet issued
        logic flush_id;       // Decode stage
        logic flush_ex;       // Execute stage
        logic flush_bp;       // Branch predictor state
        logic flush_icache;   // Instruction cache
        logic flush_tlb;      // TLBs
    } flush_vec_t;

endpackage

//--- hdl/commit_decoder.sv
// Commit event decoder

module commit_decoder import flush_pkg::*; (
    input  logic          commit_valid_i, // Instruction retires this cycle
    input  commit_op_t    commit_op_i,    // Its class
    input  logic          commit_ex_i,    // It raised an exception
    input  logic          debug_req_i,    // Debug halt request
    output commit_event_t events_o        // At most one strobe high
);

    logic commit_take; // Commit seen and not overridden by debug

    assign commit_take = commit_valid_i && !debug_req_i;

    // ------------------------------
    // Event priority
    // ------------------------------
    // Debug wins over everything, then the exception, then the op itself
    always_comb begin
        events_o = '0;
        if (debug_req_i) begin
            events_o.set_debug_pc = 1'b1;
        end else if (commit_take) begin
            if (commit_ex_i) begin
                // Trapping instruction has no side effect of its own
                events_o.ex_valid = 1'b1;
            end else begin
                case (commit_op_i)
                    OP_FENCE:      events_o.fence      = 1'b1;
                    OP_FENCE_I:    events_o.fence_i    = 1'b1;
                    OP_SFENCE_VMA: events_o.sfence_vma = 1'b1;
                    OP_CSR_SIDE:   events_o.flush_csr  = 1'b1;
                    OP_ERET:       events_o.eret       = 1'b1;
                    default: begin
                        // OP_PLAIN retires quietly
                        events_o = '0;
                    end
                endcase
            end
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    // The controller ORs the rules, so a second strobe would merge two flushes
    always_comb begin
        a_events_onehot: assert ($onehot0(events_o))
            else $error("commit_decoder: more than one event strobe");
    end

endmodule

//--- hdl/flush_ctrl.sv
// Pipeline flush and halt controller

module flush_ctrl import flush_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  commit_event_t events_i,       // Strobes from the commit decoder
    input  branch_res_t   branch_i,       // Resolved branch
    input  logic          halt_csr_i,     // Halt request from CSR, e.g. WFI
    input  logic          dcache_ack_i,   // Data cache flush finished
    output flush_vec_t    flush_o,        // Combinational flush strobes
    output logic          flush_dcache_o, // Registered data cache flush request
    output logic          halt_o          // Stall the commit stage
);

    logic mispredict;      // Qualified mispredict
    logic fence_evt;       // Either fence flavour needs the data cache flushed
    logic serialize_evt;   // Instructions that restart at the commit PC
    logic trap_evt;        // Trap entry, trap return or debug entry
    logic fence_active_d;
    logic fence_active_q;  // High from fence until dcache ack
    logic flush_dcache_d;

    assign mispredict    = branch_i.valid && branch_i.is_mispredict;
    assign fence_evt     = events_i.fence || events_i.fence_i;
    assign serialize_evt = fence_evt || events_i.sfence_vma || events_i.flush_csr;
    assign trap_evt      = events_i.ex_valid || events_i.eret || events_i.set_debug_pc;

    // ------------------------------
    // Flush vector
    // ------------------------------
    always_comb begin
        flush_o = '0;

        // Wrong path only reached the front end
        if (mispredict) begin
            flush_o.flush_if       = 1'b1;
            flush_o.flush_unissued = 1'b1;
        end

        // Serializing commits drop everything younger and refetch
        if (serialize_evt) begin
            flush_o.set_pc_commit  = 1'b1;
            flush_o.flush_if       = 1'b1;
            flush_o.flush_unissued = 1'b1;
            flush_o.flush_id       = 1'b1;
            flush_o.flush_ex       = 1'b1;
        end

        flush_o.flush_icache = events_i.fence_i;    // Code may have been rewritten
        flush_o.flush_tlb    = events_i.sfence_vma; // Translations may have changed

        // Traps redirect fetch to the trap vector, not the commit PC
        if (trap_evt) begin
            flush_o.set_pc_commit  = 1'b0;
            flush_o.flush_if       = 1'b1;
            flush_o.flush_unissued = 1'b1;
            flush_o.flush_id       = 1'b1;
            flush_o.flush_ex       = 1'b1;
            flush_o.flush_bp       = 1'b1; // Avoid speculation into the new privilege mode
        end
    end

    // ------------------------------
    // Fence tracking
    // ------------------------------
    always_comb begin
        fence_active_d = fence_active_q;
        flush_dcache_d = 1'b0;

        if (fence_evt) begin
            fence_active_d = 1'b1;
            flush_dcache_d = 1'b1;
        end

        // Request stays up until the cache answers
        if (fence_active_q && dcache_ack_i) begin
            fence_active_d = 1'b0;
        end else if (fence_active_q) begin
            flush_dcache_d = 1'b1;
        end
    end

    // Core waits while the data cache is being cleaned
    assign halt_o = halt_csr_i || fence_active_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fence_active_q <= 1'b0;
            flush_dcache_o <= 1'b0;
        end else begin
            fence_active_q <= fence_active_d;
            flush_dcache_o <= flush_dcache_d; // Registered to ease timing toward the cache
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    // The flush unit only answers a request we made
    a_ack_in_fence: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dcache_ack_i |-> fence_active_q)
        else $error("flush_ctrl: dcache ack without active fence");

    // Core is halted, so no new fence may commit before the ack
    a_no_fence_while_active: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fence_evt |-> !fence_active_q)
        else $error("flush_ctrl: fence committed during data cache flush");

endmodule

//--- hdl/dcache_flush_unit.sv
// Data cache flush unit

module dcache_flush_unit import flush_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_dcache_i, // Flush request level
    input  logic      mark_dirty_i,   // Strobe, a store dirtied a set
    input  set_idx_t  mark_set_i,     // Set that became dirty
    output logic      dcache_ack_o,   // One-cycle done pulse
    output wb_count_t wb_count_o      // Sets written back by the last flush
);

    typedef enum logic [1:0] {
        IDLE,      // Waiting for a request
        WALK,      // Looking at one set
        WRITEBACK, // Writing a dirty set back
        DONE       // Acknowledge and clean up
    } state_t;

    state_t               state_d, state_q;
    set_idx_t             set_d, set_q;       // Set under inspection
    logic [WB_CNT_W-1:0]  wb_cnt_d, wb_cnt_q; // Writeback cycles left minus one
    wb_count_t            cnt_d, cnt_q;       // Dirty sets seen in this walk
    logic [DCACHE_SETS-1:0] dirty_q;          // One bit per set
    wb_count_t            wb_count_q;
    logic                 last_set;

    assign last_set     = (set_q == set_idx_t'(DCACHE_SETS - 1));
    assign dcache_ack_o = (state_q == DONE);
    assign wb_count_o   = wb_count_q;

    // ------------------------------
    // Set walk FSM
    // ------------------------------
    always_comb begin
        state_d  = state_q;
        set_d    = set_q;
        wb_cnt_d = wb_cnt_q;
        cnt_d    = cnt_q;

        case (state_q)
            IDLE: begin
                if (flush_dcache_i) begin
                    state_d = WALK;
                    set_d   = '0;
                    cnt_d   = '0;
                end
            end
            WALK: begin
                if (dirty_q[set_q]) begin
                    state_d  = WRITEBACK;
                    wb_cnt_d = WB_CNT_W'(WB_CYCLES - 1);
                    cnt_d    = cnt_q + 1'b1;
                end else if (last_set) begin
                    state_d = DONE;
                end else begin
                    set_d = set_q + 1'b1;
                end
            end
            WRITEBACK: begin
                if (wb_cnt_q != '0) begin
                    wb_cnt_d = wb_cnt_q - 1'b1;
                end else if (last_set) begin
                    state_d = DONE;
                end else begin
                    state_d = WALK;
                    set_d   = set_q + 1'b1;
                end
            end
            default: begin
                state_d = IDLE; // DONE lasts exactly one cycle
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            set_q      <= '0;
            wb_cnt_q   <= '0;
            cnt_q      <= '0;
            dirty_q    <= '0;
            wb_count_q <= '0;
        end else begin
            state_q  <= state_d;
            set_q    <= set_d;
            wb_cnt_q <= wb_cnt_d;
            cnt_q    <= cnt_d;
            // Count becomes visible together with the ack
            if (state_d == DONE && state_q != DONE) begin
                wb_count_q <= cnt_q;
            end
            if (state_q == DONE) begin
                dirty_q <= '0; // Whole cache is clean now
            end else if (mark_dirty_i) begin
                dirty_q[mark_set_i] <= 1'b1;
            end
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    a_mark_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mark_dirty_i |-> state_q == IDLE)
        else $error("dcache_flush_unit: dirty mark during flush");

endmodule

//--- hdl/flush_top.sv
// Flush and halt control top level

module flush_top import flush_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    // Commit stage
    input  logic        commit_valid_i,
    input  commit_op_t  commit_op_i,
    input  logic        commit_ex_i,
    input  logic        debug_req_i,
    // Execute stage and CSR file
    input  branch_res_t branch_i,
    input  logic        halt_csr_i,
    // Store traffic into the data cache
    input  logic        mark_dirty_i,
    input  set_idx_t    mark_set_i,
    // To the core
    output flush_vec_t  flush_o,
    output logic        halt_o,
    output logic        dcache_ack_o,
    output wb_count_t   wb_count_o
);

    commit_event_t events;       // Decoder strobes
    logic          flush_dcache; // Controller request to the cache
    logic          dcache_ack;   // Cache done pulse

    assign dcache_ack_o = dcache_ack;

    // ------------------------------
    // Input side
    // ------------------------------
    commit_decoder u_commit_decoder (
        .commit_valid_i (commit_valid_i),
        .commit_op_i    (commit_op_i),
        .commit_ex_i    (commit_ex_i),
        .debug_req_i    (debug_req_i),
        .events_o       (events)
    );

    flush_ctrl u_flush_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .events_i       (events),
        .branch_i       (branch_i),
        .halt_csr_i     (halt_csr_i),
        .dcache_ack_i   (dcache_ack),
        .flush_o        (flush_o),
        .flush_dcache_o (flush_dcache),
        .halt_o         (halt_o)
    );

    // Output side
    dcache_flush_unit u_dcache_flush_unit (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_dcache_i (flush_dcache),
        .mark_dirty_i   (mark_dirty_i),
        .mark_set_i     (mark_set_i),
        .dcache_ack_o   (dcache_ack),
        .wb_count_o     (wb_count_o)
    );

endmodule

//--- verification/flush_tb.sv
// Flush control testbench

module flush_tb import flush_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    // ------------------------------
    // DUT signals
    // ------------------------------
    logic        clk_i;
    logic        rst_ni;
    logic        commit_valid_i;
    commit_op_t  commit_op_i;
    logic        commit_ex_i;
    logic        debug_req_i;
    branch_res_t branch_i;
    logic        halt_csr_i;
    logic        mark_dirty_i;
    set_idx_t    mark_set_i;
    flush_vec_t  flush_o;
    logic        halt_o;
    logic        dcache_ack_o;
    wb_count_t   wb_count_o;

    // Scoreboard state
    int unsigned lcg_state = 78893;
    int          cyc = 0;          // Number of the next rising edge
    int          fence_edge = 0;   // Edge that saw the fence commit
    int          ack_edge = 0;     // Edge that must see the ack
    bit          fence_on = 1'b0;
    bit          check_en = 1'b0;
    int unsigned exp_count = 0;    // Dirty sets at fence time
    wb_count_t   exp_wb = '0;      // Expected wb_count_o
    logic [DCACHE_SETS-1:0] tb_dirty = '0; // Own dirty bitmap model
    int          checks = 0;
    int          errors = 0;
    string       test_name = "reset";

    flush_top u_flush_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i; // 4 ns period
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    function automatic int unsigned count_bits(input logic [DCACHE_SETS-1:0] v);
        int unsigned n;
        n = 0;
        for (int i = 0; i < DCACHE_SETS; i++) n += v[i];
        return n;
    endfunction

    // Expected flush strobes, straight from the event rules
    function automatic flush_vec_t flush_ref(input logic valid, input commit_op_t op,
                                             input logic ex, input logic dbg,
                                             input branch_res_t br);
        flush_vec_t f;
        logic       trap;
        logic       serial;
        f      = '0;
        trap   = dbg || (valid && ex) || (valid && op == OP_ERET);
        serial = !dbg && valid && !ex && (op == OP_FENCE || op == OP_FENCE_I ||
                                          op == OP_SFENCE_VMA || op == OP_CSR_SIDE);
        if (br.valid && br.is_mispredict) begin
            f.flush_if       = 1'b1;
            f.flush_unissued = 1'b1;
        end
        if (serial || trap) begin // Both drop the whole back end
            f.flush_if       = 1'b1;
            f.flush_unissued = 1'b1;
            f.flush_id       = 1'b1;
            f.flush_ex       = 1'b1;
        end
        f.set_pc_commit = serial && !trap;
        f.flush_bp      = trap;
        f.flush_icache  = serial && op == OP_FENCE_I;
        f.flush_tlb     = serial && op == OP_SFENCE_VMA;
        return f;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("CHECK FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
        errors++;
    endtask

    // Drive one commit cycle on the falling edge
    task automatic apply_commit(input logic valid, input commit_op_t op, input logic ex,
                                input logic dbg, input logic mispredict);
        @(negedge clk_i);
        commit_valid_i = valid;
        commit_op_i    = op;
        commit_ex_i    = ex;
        debug_req_i    = dbg;
        branch_i       = '{valid: mispredict, is_mispredict: mispredict};
        mark_dirty_i   = 1'b0;
    endtask

    // Fence commit, then wait for the data cache ack
    task automatic run_fence(input commit_op_t op);
        int  waited;
        bit  seen;
        apply_commit(1'b1, op, 1'b0, 1'b0, 1'b0);
        exp_count  = count_bits(tb_dirty);
        fence_edge = cyc;
        ack_edge   = cyc + 2 + DCACHE_SETS + exp_count * WB_CYCLES;
        fence_on   = 1'b1;
        apply_commit(1'b0, OP_PLAIN, 1'b0, 1'b0, 1'b0);
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < 100) begin
            @(negedge clk_i);
            seen = dcache_ack_o;
            waited++;
        end
        if (!seen) begin
            $display("Timeout: no data cache ack in test %s", test_name);
            errors++;
        end
        @(negedge clk_i);  // Ack edge checked, halt falls now
        fence_on = 1'b0;
        tb_dirty = '0;     // Bitmap cleared by the flush
    endtask

    task automatic mark_sets(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk_i);
            mark_dirty_i = 1'b1;
            mark_set_i   = set_idx_t'(lcg_next());
            tb_dirty[mark_set_i] = 1'b1;
        end
        @(negedge clk_i);
        mark_dirty_i = 1'b0;
    endtask

    // ------------------------------
    // Comparison at each rising edge
    // ------------------------------
    always @(posedge clk_i) begin : compare
        flush_vec_t exp_flush;
        logic       exp_halt;
        logic       exp_ack;
        if (check_en) begin
            exp_flush = flush_ref(commit_valid_i, commit_op_i, commit_ex_i, debug_req_i,
                                  branch_i);
            if (fence_on && cyc == ack_edge) exp_wb = wb_count_t'(exp_count);
            exp_halt = halt_csr_i || (fence_on && cyc > fence_edge && cyc <= ack_edge);
            exp_ack  = fence_on && cyc == ack_edge;
            checks++;
            if (flush_o !== exp_flush) report_mismatch("flush_o", 32'(exp_flush), 32'(flush_o));
            if (halt_o !== exp_halt) report_mismatch("halt_o", 32'(exp_halt), 32'(halt_o));
            if (dcache_ack_o !== exp_ack) begin
                report_mismatch("dcache_ack_o", 32'(exp_ack), 32'(dcache_ack_o));
            end
            if (wb_count_o !== exp_wb) report_mismatch("wb_count_o", 32'(exp_wb), 32'(wb_count_o));
        end
        cyc++;
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        int unsigned r;
        rst_ni = 1'b0;
        commit_valid_i = 1'b0;
        commit_op_i = OP_PLAIN;
        commit_ex_i = 1'b0;
        debug_req_i = 1'b0;
        branch_i = '0;
        halt_csr_i = 1'b0;
        mark_dirty_i = 1'b0;
        mark_set_i = '0;
        repeat (4) @(posedge clk_i); // Four rising edges in reset
        @(negedge clk_i);
        rst_ni = 1'b1;
        check_en = 1'b1;
        test_name = "halt_csr";  // Halt simply follows the CSR request
        repeat (2) @(negedge clk_i);
        halt_csr_i = 1'b1;
        repeat (3) @(negedge clk_i);
        halt_csr_i = 1'b0;

        test_name = "random";    // No fences here, so marks are always legal
        for (int i = 0; i < 80; i++) begin
            r = lcg_next();
            apply_commit(r[0], commit_op_t'(0), r[6:4] == 3'd0, r[10:7] == 4'd0, r[11]);
            case (r[3:2])
                2'd0: commit_op_i = OP_PLAIN;
                2'd1: commit_op_i = OP_SFENCE_VMA;
                2'd2: commit_op_i = OP_CSR_SIDE;
                default: commit_op_i = OP_ERET;
            endcase
            branch_i.is_mispredict = r[12];
            halt_csr_i   = r[15:13] == 3'd0;
            mark_dirty_i = r[1];
            mark_set_i   = set_idx_t'(lcg_next());
            if (mark_dirty_i) tb_dirty[mark_set_i] = 1'b1;
        end
        apply_commit(1'b0, OP_PLAIN, 1'b0, 1'b0, 1'b0);
        halt_csr_i = 1'b0;

        test_name = "traps";
        apply_commit(1'b1, OP_SFENCE_VMA, 1'b1, 1'b0, 1'b0);
        @(posedge clk_i);        // Exception hides the TLB flush
        if (flush_o.flush_tlb !== 1'b0) report_mismatch("flush_tlb", 0, 32'(flush_o.flush_tlb));
        if (flush_o.flush_bp !== 1'b1) report_mismatch("flush_bp", 1, 32'(flush_o.flush_bp));
        apply_commit(1'b1, OP_ERET, 1'b0, 1'b0, 1'b1);
        @(posedge clk_i);
        if (flush_o.set_pc_commit !== 1'b0) begin
            report_mismatch("set_pc_commit", 0, 32'(flush_o.set_pc_commit));
        end
        apply_commit(1'b1, OP_FENCE, 1'b0, 1'b1, 1'b0); // Debug wins, no fence starts
        apply_commit(1'b1, OP_FENCE_I, 1'b1, 1'b0, 1'b0);
        @(posedge clk_i);
        if (flush_o.flush_icache !== 1'b0) begin
            report_mismatch("flush_icache", 0, 32'(flush_o.flush_icache));
        end
        apply_commit(1'b0, OP_PLAIN, 1'b0, 1'b0, 1'b0);

        test_name = "fence";
        mark_sets(5);
        run_fence(OP_FENCE);
        test_name = "fence_i";
        mark_sets(3);
        run_fence(OP_FENCE_I);
        test_name = "fence_clean"; // Bitmap was cleared, count is zero
        run_fence(OP_FENCE);
        repeat (3) @(negedge clk_i);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- list.f
hdl/flush_pkg.sv
hdl/commit_decoder.sv
hdl/flush_ctrl.sv
hdl/dcache_flush_unit.sv
hdl/flush_top.sv
verification/flush_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the flush control simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module flush_tb -f list.f -o flush_sim

out=$(./obj_dir/flush_sim)
echo "$out"

if echo "$out" | grep -q "^Simulation completed successfully$"; then
    exit 0
fi
exit 1
